// File: Bender.yml
package:
  name: forth_core

sources:
  - files:
      - hw/forth_isa_pkg.sv
      - hw/stack_cfg_pkg.sv
      - hw/credit_fifo.sv
      - hw/forth_decode.sv
      - hw/forth_alu.sv
      - hw/data_stack.sv
      - hw/emit_port.sv
      - hw/forth_core.sv
  - target: test
    files:
      - verif/forth_core_assert.sv
      - verif/forth_core_tb.sv

// File: hw/credit_fifo.sv
// instruction input queue
// circular buffer, one credit back to the source per entry handed to decode
`timescale 1ns/100ps

module credit_fifo
    import forth_isa_pkg::*;
    import stack_cfg_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,   // source holds a credit
    input  logic [INSTR_W-1:0] in_instr,
    output logic               in_credit,  // one pulse per dequeue
    output logic               q_valid,
    output logic [INSTR_W-1:0] q_instr,
    input  logic               q_take
);

    logic [INSTR_W-1:0] mem [IN_CREDITS];
    logic [FIFO_AW:0]   wr_ptr;            // extra bit tells full from empty
    logic [FIFO_AW:0]   rd_ptr;
    logic [FIFO_AW:0]   fill;
    logic               deq;

    assign fill    = wr_ptr - rd_ptr;
    assign q_valid = (fill != '0);
    assign q_instr = mem[rd_ptr[FIFO_AW-1:0]];
    assign deq     = q_valid && q_take;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) wr_ptr <= wr_ptr + 1'b1;  // credit rule keeps this from full
            if (deq)      rd_ptr <= rd_ptr + 1'b1;
            in_credit <= deq;                       // slot freed, hand credit back
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) mem[wr_ptr[FIFO_AW-1:0]] <= in_instr;
    end

endmodule

// File: hw/data_stack.sv
// stack execute stage
// tos and nos in registers, deeper cells in memory, depth checks with sticky error
`timescale 1ns/100ps

module data_stack
    import forth_isa_pkg::*;
    import stack_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              dec_valid,
    input  forth_op_e         dec_op,
    input  alu_op_e           dec_alu,
    input  logic [IMM_W-1:0]  dec_imm,
    input  logic [1:0]        dec_pops,
    input  logic [1:0]        dec_pushes,
    input  logic              dec_emit,
    output logic              dec_ready,
    output logic              emit_valid,
    output logic [DATA_W-1:0] emit_data,
    input  logic              emit_ready,
    output logic              stack_err
);

    logic [DATA_W-1:0] mem [MEM_DEPTH];
    logic [DATA_W-1:0] tos, nos;
    logic [DATA_W-1:0] tos_nxt, nos_nxt;
    logic [DATA_W-1:0] alu_res, mem_rdata, pick_val;
    logic [SP_W-1:0]   cnt;                 // items on the stack
    logic [SP_W-1:0]   cnt_nxt;
    logic [MEM_AW-1:0] mem_ptr;             // next free memory cell
    logic [MEM_AW-1:0] pick_addr, mem_raddr;
    logic              need_ok, room_ok, viol;
    logic              exec, do_op, grow;

    forth_alu u_alu (
        .alu_op (dec_alu),
        .tos    (tos),
        .nos    (nos),
        .result (alu_res)
    );

    assign mem_ptr   = MEM_AW'(cnt - SP_W'(2));            // cells below nos
    assign pick_addr = mem_ptr + MEM_AW'(1) - dec_imm[MEM_AW-1:0];  // pointer plus offset
    assign mem_raddr = (dec_op == OP_PICK) ? pick_addr : mem_ptr - 1'b1;  // pop reads ptr-1
    assign mem_rdata = mem[mem_raddr];

    // depth checks against the decoded effect
    assign cnt_nxt = cnt + SP_W'(dec_pushes) - SP_W'(dec_pops);
    assign need_ok = (cnt >= SP_W'(dec_pops))
                  && ((dec_op != OP_PICK) || (IMM_W'(cnt) > dec_imm));  // pick needs imm+1
    assign room_ok = (cnt_nxt <= SP_W'(STACK_DEPTH));
    assign viol    = !(need_ok && room_ok);

    assign dec_ready  = viol || !dec_emit || emit_ready;  // only a live emit waits
    assign exec       = dec_valid && dec_ready;
    assign do_op      = exec && !viol;
    assign grow       = dec_pushes > dec_pops;
    assign emit_valid = dec_valid && dec_emit && !viol;  // skipped emit sends nothing
    assign emit_data  = tos;

    always_comb begin
        case (dec_imm)
            IMM_W'(0): pick_val = tos;     // pick 0 is dup in place
            IMM_W'(1): pick_val = nos;
            default:   pick_val = mem_rdata;
        endcase
    end

    always_comb begin
        tos_nxt = tos;
        nos_nxt = nos;
        case (dec_op)
            OP_LIT: begin
                tos_nxt = DATA_W'(dec_imm);
                nos_nxt = tos;
            end
            OP_DUP:  nos_nxt = tos;
            OP_OVER, OP_SWAP: begin         // over also pushes old nos below
                tos_nxt = nos;
                nos_nxt = tos;
            end
            OP_DROP, OP_EMIT: begin
                tos_nxt = nos;
                nos_nxt = mem_rdata;        // refill from memory
            end
            OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
                tos_nxt = alu_res;
                nos_nxt = mem_rdata;
            end
            OP_PICK: tos_nxt = pick_val;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt       <= '0;
            stack_err <= 1'b0;
        end else begin
            if (do_op) cnt <= cnt_nxt;
            if (exec && viol) stack_err <= 1'b1;  // sticky
        end
    end

    always_ff @(posedge clk) begin
        if (do_op) begin
            tos <= tos_nxt;
            nos <= nos_nxt;
            if (grow && (cnt >= SP_W'(2))) mem[mem_ptr] <= nos;  // spill nos
        end
    end

endmodule

// File: hw/emit_port.sv
// emit output port
// one-entry holding register, registered out_valid paced by sink credits
`timescale 1ns/100ps

module emit_port
    import stack_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              emit_valid,
    input  logic [DATA_W-1:0] emit_data,
    output logic              emit_ready,
    output logic              out_valid,
    output logic [DATA_W-1:0] out_data,
    input  logic              out_credit
);

    logic [DATA_W-1:0] hold_data;
    logic              hold_valid;
    logic [CRED_W-1:0] credits;       // sink credits on hand
    logic [CRED_W-1:0] credits_nxt;
    logic              send;
    logic              accept;

    assign credits_nxt = credits + CRED_W'(out_credit) - CRED_W'(out_valid);
    assign send        = hold_valid && (credits_nxt != '0);  // credit still there next cycle
    assign emit_ready  = !hold_valid || send;                // free or draining
    assign accept      = emit_valid && emit_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hold_valid <= 1'b0;
            out_valid  <= 1'b0;
            credits    <= CRED_W'(SINK_CREDITS);
        end else begin
            credits   <= credits_nxt;
            out_valid <= send;                    // single cycle pulse
            if (accept)    hold_valid <= 1'b1;
            else if (send) hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) hold_data <= emit_data;
        if (send)   out_data  <= hold_data;      // old value leaves as new one lands
    end

endmodule

// File: hw/forth_alu.sv
// stack alu, nos op tos with 16 bit wraparound
`timescale 1ns/100ps

module forth_alu
    import forth_isa_pkg::*;
    import stack_cfg_pkg::*;
(
    input  alu_op_e           alu_op,
    input  logic [DATA_W-1:0] tos,
    input  logic [DATA_W-1:0] nos,
    output logic [DATA_W-1:0] result
);

    always_comb begin
        case (alu_op)
            ALU_ADD: result = nos + tos;  // carry dropped
            ALU_SUB: result = nos - tos;  // second minus top
            ALU_AND: result = nos & tos;
            ALU_XOR: result = nos ^ tos;
            default: result = tos;        // pass
        endcase
    end

endmodule

// File: hw/forth_core.sv
// forth execution core
// input queue, decode, stack execute and emit port in a chain
`timescale 1ns/100ps

module forth_core
    import forth_isa_pkg::*;
    import stack_cfg_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,
    input  logic [INSTR_W-1:0] in_instr,
    output logic               in_credit,
    output logic               out_valid,
    output logic [DATA_W-1:0]  out_data,
    input  logic               out_credit,
    output logic               stack_err
);

    logic               q_valid, q_take;
    logic [INSTR_W-1:0] q_instr;
    logic               dec_valid, dec_ready, dec_emit;
    forth_op_e          dec_op;
    alu_op_e            dec_alu;
    logic [IMM_W-1:0]   dec_imm;
    logic [1:0]         dec_pops, dec_pushes;
    logic               emit_valid, emit_ready;
    logic [DATA_W-1:0]  emit_data;

    credit_fifo u_fifo (
        .clk, .arst_n, .in_valid, .in_instr, .in_credit,
        .q_valid, .q_instr, .q_take
    );

    forth_decode u_decode (
        .clk, .arst_n, .q_valid, .q_instr, .q_take,
        .dec_valid, .dec_op, .dec_alu, .dec_imm,
        .dec_pops, .dec_pushes, .dec_emit, .dec_ready
    );

    data_stack u_stack (
        .clk, .arst_n, .dec_valid, .dec_op, .dec_alu, .dec_imm,
        .dec_pops, .dec_pushes, .dec_emit, .dec_ready,
        .emit_valid, .emit_data, .emit_ready, .stack_err
    );

    emit_port u_emit (
        .clk, .arst_n, .emit_valid, .emit_data, .emit_ready,
        .out_valid, .out_data, .out_credit
    );

endmodule

// File: hw/forth_decode.sv
// instruction decode stage
// registers opcode, stack effect, alu op and emit flag for the stack stage
`timescale 1ns/100ps

module forth_decode
    import forth_isa_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               q_valid,
    input  logic [INSTR_W-1:0] q_instr,
    output logic               q_take,
    output logic               dec_valid,
    output forth_op_e          dec_op,
    output alu_op_e            dec_alu,
    output logic [IMM_W-1:0]   dec_imm,
    output logic [1:0]         dec_pops,    // items consumed, also the minimum depth
    output logic [1:0]         dec_pushes,  // items produced
    output logic               dec_emit,
    input  logic               dec_ready
);

    forth_instr_t instr;
    forth_op_e    op_d;
    alu_op_e      alu_d;
    logic [1:0]   pops_d;
    logic [1:0]   pushes_d;
    logic         load;

    assign instr  = forth_instr_t'(q_instr);
    assign q_take = !dec_valid || dec_ready;  // empty or draining
    assign load   = q_take && q_valid;

    always_comb begin
        op_d     = OP_NOP;
        alu_d    = ALU_PASS;
        pops_d   = 2'd0;
        pushes_d = 2'd0;
        case (instr.opc)
            OP_LIT:  begin op_d = OP_LIT;  pushes_d = 2'd1; end
            OP_DUP:  begin op_d = OP_DUP;  pops_d = 2'd1; pushes_d = 2'd2; end
            OP_OVER: begin op_d = OP_OVER; pops_d = 2'd2; pushes_d = 2'd3; end
            OP_SWAP: begin op_d = OP_SWAP; pops_d = 2'd2; pushes_d = 2'd2; end
            OP_DROP: begin op_d = OP_DROP; pops_d = 2'd1; end
            OP_EMIT: begin op_d = OP_EMIT; pops_d = 2'd1; end
            OP_ADD:  begin op_d = OP_ADD;  alu_d = ALU_ADD; pops_d = 2'd2; pushes_d = 2'd1; end
            OP_SUB:  begin op_d = OP_SUB;  alu_d = ALU_SUB; pops_d = 2'd2; pushes_d = 2'd1; end
            OP_AND:  begin op_d = OP_AND;  alu_d = ALU_AND; pops_d = 2'd2; pushes_d = 2'd1; end
            OP_XOR:  begin op_d = OP_XOR;  alu_d = ALU_XOR; pops_d = 2'd2; pushes_d = 2'd1; end
            OP_PICK: begin op_d = OP_PICK; pops_d = 2'd1; pushes_d = 2'd1; end  // imm depth checked later
            default: ;                                                          // unknown is nop
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) dec_valid <= 1'b0;
        else if (q_take) dec_valid <= q_valid;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            dec_op     <= op_d;
            dec_alu    <= alu_d;
            dec_imm    <= instr.imm;
            dec_pops   <= pops_d;
            dec_pushes <= pushes_d;
            dec_emit   <= (op_d == OP_EMIT);
        end
    end

endmodule

// File: hw/forth_isa_pkg.sv
// forth instruction set
// opcode and alu encodings plus the instruction word layout
package forth_isa_pkg;

    localparam int OPC_W   = 4;             // opcode field
    localparam int IMM_W   = 16;            // immediate field
    localparam int INSTR_W = OPC_W + IMM_W; // full instruction word

    typedef enum logic [OPC_W-1:0] {
        OP_NOP  = 4'h0,
        OP_LIT  = 4'h1,  // push imm
        OP_DUP  = 4'h2,
        OP_DROP = 4'h3,
        OP_SWAP = 4'h4,
        OP_OVER = 4'h5,
        OP_ADD  = 4'h6,
        OP_SUB  = 4'h7,
        OP_AND  = 4'h8,
        OP_XOR  = 4'h9,
        OP_PICK = 4'ha,  // tos <= item imm, counted from tos
        OP_EMIT = 4'hb   // pop tos to the output
    } forth_op_e;

    typedef enum logic [2:0] {
        ALU_PASS,        // forward tos
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_XOR
    } alu_op_e;

    // opcode in the upper bits
    typedef struct packed {
        logic [OPC_W-1:0] opc;
        logic [IMM_W-1:0] imm;
    } forth_instr_t;

endpackage

// File: hw/stack_cfg_pkg.sv
// data stack and flow control configuration
package stack_cfg_pkg;

    localparam int DATA_W       = 16;                  // stack cell width
    localparam int STACK_DEPTH  = 16;                  // total cells incl tos and nos
    localparam int SP_W         = 5;                   // holds 0..STACK_DEPTH
    localparam int MEM_DEPTH    = STACK_DEPTH - 2;     // cells below nos
    localparam int MEM_AW       = $clog2(MEM_DEPTH);

    localparam int IN_CREDITS   = 4;                   // input queue depth
    localparam int FIFO_AW      = $clog2(IN_CREDITS);

    localparam int SINK_CREDITS = 2;                   // initial sink credits
    localparam int CRED_W       = $clog2(SINK_CREDITS + 1);

endpackage

// File: verif/forth_core_assert.sv
// credit and flow rules for the input queue and the emit port
// one checker, bound into both blocks with the unused side tied off
`timescale 1ns/100ps

module forth_core_assert
    import stack_cfg_pkg::*;
(
    input logic              clk,
    input logic              arst_n,
    input logic              in_valid,
    input logic [FIFO_AW:0]  fill,       // queue occupancy
    input logic              out_valid,
    input logic [CRED_W-1:0] credits     // sink credits on hand
);

    int fail_cnt = 0;                    // failed rules so far

    no_full_write: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid |-> (fill < IN_CREDITS))
        else begin
            $error("input queue written while full");
            fail_cnt++;
        end

    no_send_without_credit: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> (credits != '0))
        else begin
            $error("out_valid raised with no sink credit");
            fail_cnt++;
        end

    credits_bounded: assert property (@(posedge clk) disable iff (!arst_n)
        credits <= SINK_CREDITS)
        else begin
            $error("sink credit count above its initial value");
            fail_cnt++;
        end

endmodule

bind credit_fifo forth_core_assert fifo_chk (
    .clk, .arst_n, .in_valid, .fill, .out_valid(1'b0), .credits('0)
);

bind emit_port forth_core_assert emit_chk (
    .clk, .arst_n, .in_valid(1'b0), .fill('0), .out_valid, .credits
);

// File: verif/forth_core_tb.sv
// forth core testbench
// directed and random programs checked against a stack model, credit driven source and sink
`timescale 1ns/100ps

module forth_core_tb
    import forth_isa_pkg::*;
    import stack_cfg_pkg::*;
();

    localparam int WAIT_LIMIT = 8000;         // cycles before a wait gives up

    logic               clk;
    logic               arst_n;
    logic               in_valid;
    logic [INSTR_W-1:0] in_instr;
    logic               in_credit;
    logic               out_valid;
    logic [DATA_W-1:0]  out_data;
    logic               out_credit;
    logic               stack_err;

    integer             seed;
    logic [INSTR_W-1:0] prog_q[$];            // waiting for an input credit
    logic [DATA_W-1:0]  exp_q[$];             // expected emits, oldest first
    logic [DATA_W-1:0]  st [STACK_DEPTH];     // model stack, top at depth-1
    logic [DATA_W-1:0]  want;
    int                 depth;
    logic               exp_err;              // model copy of the sticky flag
    int                 src_credits;
    int                 owed;                 // sink credits not yet returned
    int                 gap;
    int                 credits_ret;
    int                 out_pulses;
    logic               slow_sink;            // long credit stalls
    int                 i;

    forth_core dut0 (
        .clk, .arst_n, .in_valid, .in_instr, .in_credit,
        .out_valid, .out_data, .out_credit, .stack_err
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // items an opcode needs on the stack
    function automatic int need_of(input logic [OPC_W-1:0] opc, input logic [IMM_W-1:0] imm);
        case (opc)
            OP_DUP, OP_DROP, OP_EMIT: return 1;
            OP_SWAP, OP_OVER, OP_ADD, OP_SUB, OP_AND, OP_XOR: return 2;
            OP_PICK: return int'(imm) + 1;
            default: return 0;            // nop and unknown
        endcase
    endfunction

    function automatic int net_of(input logic [OPC_W-1:0] opc);
        case (opc)
            OP_LIT, OP_DUP, OP_OVER: return 1;
            OP_DROP, OP_EMIT, OP_ADD, OP_SUB, OP_AND, OP_XOR: return -1;
            default: return 0;
        endcase
    endfunction

    function automatic bit op_legal(input logic [OPC_W-1:0] opc, input logic [IMM_W-1:0] imm);
        return (depth >= need_of(opc, imm)) && (depth + net_of(opc) <= STACK_DEPTH);
    endfunction

    // reference model, one instruction
    function automatic void model_exec(input logic [INSTR_W-1:0] instr);
        logic [OPC_W-1:0]  opc;
        logic [IMM_W-1:0]  imm;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        opc = instr[INSTR_W-1:IMM_W];
        imm = instr[IMM_W-1:0];
        if (!op_legal(opc, imm)) begin
            exp_err = 1'b1;               // skipped, flag sticks
            return;
        end
        a = (depth > 0) ? st[depth-1] : '0;  // top
        b = (depth > 1) ? st[depth-2] : '0;  // second
        case (opc)
            OP_LIT:  st[depth] = imm;
            OP_DUP:  st[depth] = a;
            OP_OVER: st[depth] = b;
            OP_EMIT: exp_q.push_back(a);
            OP_SWAP: begin
                st[depth-1] = b;
                st[depth-2] = a;
            end
            OP_ADD:  st[depth-2] = b + a;  // wraps at 16 bits
            OP_SUB:  st[depth-2] = b - a;
            OP_AND:  st[depth-2] = b & a;
            OP_XOR:  st[depth-2] = b ^ a;
            OP_PICK: st[depth-1] = st[depth-1-int'(imm)];
            default: ;
        endcase
        depth = depth + net_of(opc);
    endfunction

    task automatic put(input logic [OPC_W-1:0] opc, input logic [IMM_W-1:0] imm);
        model_exec({opc, imm});
        prog_q.push_back({opc, imm});
    endtask

    task automatic op_then_emit(input logic [OPC_W-1:0] opc, input logic [IMM_W-1:0] imm);
        put(opc, imm);
        put(OP_EMIT, '0);
    endtask

    task automatic binop(input logic [OPC_W-1:0] opc, input logic [IMM_W-1:0] a,
                         input logic [IMM_W-1:0] b);
        put(OP_LIT, a);
        put(OP_LIT, b);
        op_then_emit(opc, '0);
    endtask

    // random op kept inside the legal depth range
    task automatic random_legal_op();
        logic [31:0]      r;
        logic [OPC_W-1:0] opc;
        logic [IMM_W-1:0] imm;
        r   = $random(seed);
        opc = OPC_W'(r[7:0] % 12);
        imm = r[31:16];
        if (r[9:8] == 2'b00) opc = OP_LIT;  // keeps the stack from running dry
        if (opc == OP_PICK) imm = (depth > 0) ? IMM_W'(int'(imm) % depth) : '0;
        if (!op_legal(opc, imm)) opc = (depth < 2) ? OP_LIT : OP_EMIT;
        put(opc, imm);
    endtask

    // closing emit, then wait for every expected output
    task automatic drain_phase(input string name);
        int waited;
        waited = 0;
        if (depth == 0) put(OP_LIT, 16'h0c0d);
        put(OP_EMIT, '0);
        while (prog_q.size() != 0 || exp_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run({"timeout: phase ", name, " did not deliver all its outputs"});
        end
        assert (stack_err == exp_err)
            else abort_run($sformatf("** Error: stack_err = 0x%h, expected 0x%h",
                                     stack_err, exp_err));
        @(posedge clk);
    endtask

    // source side, one credit per instruction sent
    always @(negedge clk) begin
        if (in_credit) src_credits++;
        if (arst_n && src_credits > 0 && prog_q.size() > 0) begin
            in_instr = prog_q.pop_front();
            in_valid = 1'b1;
            src_credits--;
        end else begin
            in_valid = 1'b0;
        end
    end

    // sink side, hands credits back after a random delay
    always @(negedge clk) begin
        if (out_valid) begin
            out_pulses++;
            owed++;
            assert (out_pulses <= credits_ret + SINK_CREDITS)
                else abort_run("more outputs than the sink granted credits for");
        end
        out_credit = 1'b0;
        if (gap > 0) begin
            gap--;
        end else if (owed > 0) begin
            out_credit = 1'b1;
            owed--;
            credits_ret++;
            gap = slow_sink ? 20 + rand_below(60) : rand_below(3);
        end
    end

    // output compare against the model queue
    always @(negedge clk) begin
        if (out_valid) begin
            assert (exp_q.size() > 0)
                else abort_run("an output arrived that the model did not expect");
            want = exp_q.pop_front();
            assert (out_data == want)
                else abort_run($sformatf("** Error: out_data = 0x%h, expected 0x%h",
                                         out_data, want));
        end
    end

    // bound flow control rules
    always @(negedge clk) begin
        if (dut0.u_fifo.fifo_chk.fail_cnt + dut0.u_emit.emit_chk.fail_cnt != 0)
            abort_run("a bound flow control assertion failed");
    end

    initial begin
        seed        = 32'h9295_2d4e;
        arst_n      = 1'b0;
        in_valid    = 1'b0;
        in_instr    = '0;
        out_credit  = 1'b0;
        depth       = 0;
        exp_err     = 1'b0;
        src_credits = IN_CREDITS;
        owed        = 0;
        gap         = 0;
        credits_ret = 0;
        out_pulses  = 0;
        slow_sink   = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        assert (!in_credit && !out_valid && !stack_err)
            else abort_run("core outputs were not idle after reset");
        @(posedge clk);

        binop(OP_ADD, 16'hfff0, 16'h0025);  // carry out dropped
        binop(OP_SUB, 16'h0003, 16'h0005);  // borrow wraps
        binop(OP_AND, 16'hf0f0, 16'h3c3c);
        binop(OP_XOR, 16'ha5a5, 16'h0ff0);
        binop(OP_ADD, 16'hffff, 16'hffff);
        drain_phase("arithmetic");

        for (i = 0; i < 14; i++) put(OP_LIT, IMM_W'(16'h1000 + i * 16'h0111));
        op_then_emit(OP_DUP, '0);
        op_then_emit(OP_SWAP, '0);
        op_then_emit(OP_OVER, '0);
        op_then_emit(OP_PICK, 16'd0);
        op_then_emit(OP_PICK, 16'd1);
        op_then_emit(OP_PICK, 16'd4);
        op_then_emit(OP_PICK, 16'd8);       // reaches into memory
        put(OP_DROP, '0);
        op_then_emit(OP_SWAP, '0);
        while (depth > 0) put(OP_EMIT, '0);
        drain_phase("shuffles");

        for (i = 0; i < 17; i++) put(OP_LIT, IMM_W'(16'h2000 + i));  // last one overflows
        op_then_emit(OP_ADD, '0);
        op_then_emit(OP_XOR, '0);
        op_then_emit(OP_PICK, 16'd10);
        while (depth > 0) put(OP_EMIT, '0);
        drain_phase("overflow");

        put(OP_EMIT, '0);                   // empty stack, nothing comes out
        drain_phase("empty emit");

        for (i = 0; i < 300; i++) random_legal_op();
        drain_phase("random");

        slow_sink = 1'b1;
        for (i = 0; i < 24; i++) op_then_emit(OP_LIT, IMM_W'(16'h5000 + i * 7));
        drain_phase("back-pressure");
        slow_sink = 1'b0;

        put(OP_LIT, '0);                    // running sum shows any lost or doubled op
        for (i = 1; i <= 40; i++) begin
            put(OP_LIT, IMM_W'(i * 16'h0101));
            put(OP_ADD, '0);
            op_then_emit(OP_DUP, '0);
        end
        drain_phase("input bursts");

        i = 0;
        while (src_credits != IN_CREDITS) begin
            @(negedge clk);
            i++;
            if (i > WAIT_LIMIT) abort_run("timeout: input credits never all came back");
        end
        if (dut0.u_fifo.fifo_chk.fail_cnt + dut0.u_emit.emit_chk.fail_cnt != 0) begin
            abort_run("bound protocol assertions reported failures");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// File: vlog.f
hw/forth_isa_pkg.sv
hw/stack_cfg_pkg.sv
hw/credit_fifo.sv
hw/forth_decode.sv
hw/forth_alu.sv
hw/data_stack.sv
hw/emit_port.sv
hw/forth_core.sv
verif/forth_core_assert.sv
verif/forth_core_tb.sv
